//--- cp0.f
+incdir+hdl
hdl/cp0Pkg.sv
hdl/cp0RegBus.sv
hdl/apbRegPort.sv
hdl/excUnit.sv
hdl/timerUnit.sv
hdl/cp0Top.sv
test/cp0_sva.sv
test/cp0Tb.sv

//--- Bender.yml
package:
  name: cp0

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/cp0Pkg.sv
      - hdl/cp0RegBus.sv
      - hdl/apbRegPort.sv
      - hdl/excUnit.sv
      - hdl/timerUnit.sv
      - hdl/cp0Top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/cp0_sva.sv
      - test/cp0Tb.sv

//--- test/cp0Tb.sv
/*
 * CP0 testbench
 * Table-driven APB and exception stimulus, timer checks and a watchdog
 */
`timescale 1ns/10ps
`include "cp0_settings.svh"

module cp0Tb import cp0Pkg::*; ();

    typedef enum int {opWr, opRd, opExc, opInt, opWait} opT;
    typedef enum int {selUm, selTmr, selIp, selSt, selEpc, selCs} selT;  // Output checked by a wait row

    logic clk;
    logic rst;
    logic psel_i;
    logic penable_i;
    logic pwrite_i;
    logic [`CP0_PADDR_W-1:0] paddr_i;
    wordT pwdata_i;
    wordT prdata_o;
    logic pready_o;
    logic pslverr_o;
    logic exc_valid_i;
    excTypeT exc_type_i;
    wordT pc_i;
    wordT bad_addr_i;
    logic in_slot_i;
    cpNumT cp_num_i;
    hwIntT int_i;
    wordT status_o;
    wordT cause_o;
    wordT epc_o;
    logic usermode_o;
    logic timer_int_o;

    // Stimulus table, one entry per row in each queue
    opT    opQ[$];
    int    argQ[$];    // Register number, exception type or output select
    wordT  dataQ[$];   // Write data, cp_num, int_i value or wait cycles
    wordT  pcQ[$];
    wordT  badQ[$];
    logic  slotQ[$];
    wordT  expQ[$];
    string nameQ[$];

    int   errors;
    int   checks;
    logic rowsReady;
    wordT lcgState;

    cp0Top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic wordT lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic isMapped(input regNumT num);
        return num inside {`CP0_BADVADDR, `CP0_COUNT, `CP0_COMPARE, `CP0_STATUS,
                           `CP0_CAUSE, `CP0_EPC, `CP0_PRID};
    endfunction

    task automatic checkValue(input string name, input wordT expVal, input wordT actVal);
        checks++;
        if (actVal !== expVal) begin
            errors++;
            $display("error %s: expected %h, actual %h", name, expVal, actVal);
        end
    endtask

    // One APB transfer, setup then access
    task automatic apbXfer(input logic wr, input regNumT num, input wordT data,
                           output wordT rdVal, output logic errVal);
        int waitCnt;
        waitCnt = 0;
        @(posedge clk);
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        pwrite_i  <= wr;
        paddr_i   <= {num, 2'b00};
        pwdata_i  <= data;
        @(posedge clk);
        penable_i <= 1'b1;
        @(negedge clk);
        while (!pready_o && waitCnt < 16) begin
            @(negedge clk);
            waitCnt++;
        end
        if (!pready_o) begin
            errors++;
            $display("APB transfer to register %0d never got pready", num);
        end
        rdVal  = prdata_o;
        errVal = pslverr_o;
        @(posedge clk);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
        pwrite_i  <= 1'b0;
    endtask

    task automatic addRow(input string name, input opT op, input int arg, input wordT data,
                          input wordT pcVal, input wordT badVal, input logic slot,
                          input wordT expVal);
        nameQ.push_back(name);
        opQ.push_back(op);
        argQ.push_back(arg);
        dataQ.push_back(data);
        pcQ.push_back(pcVal);
        badQ.push_back(badVal);
        slotQ.push_back(slot);
        expQ.push_back(expVal);
    endtask

    task automatic buildTable();
        wordT epcVal;
        wordT badVal;
        wordT pcA;
        wordT badA;
        epcVal = lcgNext();
        badVal = lcgNext();
        pcA    = 32'hBFC0_0104;
        badA   = 32'h0000_0123;  // Misaligned load
        addRow("status reset", opRd, `CP0_STATUS, 0, 0, 0, 0, `STATUS_RST);
        addRow("status out reset", opWait, selSt, 0, 0, 0, 0, `STATUS_RST);
        addRow("cause reset", opRd, `CP0_CAUSE, 0, 0, 0, 0, 0);
        addRow("epc reset", opRd, `CP0_EPC, 0, 0, 0, 0, 0);
        addRow("prid reset", opRd, `CP0_PRID, 0, 0, 0, 0, `PRID_VALUE);
        addRow("usermode reset", opWait, selUm, 0, 0, 0, 0, 0);
        addRow("timer int reset", opWait, selTmr, 0, 0, 0, 0, 0);
        addRow("status write", opWr, `CP0_STATUS, 32'hFFFF_FFFF, 0, 0, 0, 0);
        addRow("status masked", opRd, `CP0_STATUS, 0, 0, 0, 0, `STATUS_WMASK);
        addRow("cause write", opWr, `CP0_CAUSE, 32'hFFFF_FFFF, 0, 0, 0, 0);
        addRow("cause masked", opRd, `CP0_CAUSE, 0, 0, 0, 0, 32'h0080_0300);  // IV, IP[1:0]
        addRow("epc write", opWr, `CP0_EPC, epcVal, 0, 0, 0, 0);
        addRow("epc read", opRd, `CP0_EPC, 0, 0, 0, 0, epcVal);
        addRow("badvaddr write", opWr, `CP0_BADVADDR, badVal, 0, 0, 0, 0);
        addRow("badvaddr read", opRd, `CP0_BADVADDR, 0, 0, 0, 0, badVal);
        addRow("prid write", opWr, `CP0_PRID, 32'hFFFF_FFFF, 0, 0, 0, 0);
        addRow("prid read only", opRd, `CP0_PRID, 0, 0, 0, 0, `PRID_VALUE);
        addRow("unmapped read", opRd, 3, 0, 0, 0, 0, 0);
        addRow("usermode write", opWr, `CP0_STATUS, 32'h0000_0010, 0, 0, 0, 0);
        addRow("usermode high", opWait, selUm, 1, 0, 0, 0, 1);
        addRow("adel entry", opExc, `EXCT_ADEL, 0, pcA, badA, 1, 0);
        addRow("usermode low", opWait, selUm, 1, 0, 0, 0, 0);
        addRow("adel epc", opRd, `CP0_EPC, 0, 0, 0, 0, pcA - 32'd4);
        addRow("adel epc out", opWait, selEpc, 0, 0, 0, 0, pcA - 32'd4);
        addRow("adel cause", opRd, `CP0_CAUSE, 0, 0, 0, 0,
               32'h8080_0300 | (`EXCC_ADEL << 2));
        addRow("adel badvaddr", opRd, `CP0_BADVADDR, 0, 0, 0, 0, badA);
        addRow("cpu entry", opExc, `EXCT_CPU, 2, 32'hBFC0_0200, 0, 0, 0);
        addRow("nested epc", opRd, `CP0_EPC, 0, 0, 0, 0, pcA - 32'd4);
        addRow("cpu cause", opRd, `CP0_CAUSE, 0, 0, 0, 0,
               32'hA080_0300 | (`EXCC_CPU << 2));  // BD kept, CE 2
        addRow("cpu cause out", opWait, selCs, 0, 0, 0, 0,
               32'hA080_0300 | (`EXCC_CPU << 2));
        addRow("eret", opExc, `EXCT_ERET, 0, 0, 0, 0, 0);
        addRow("status after eret", opRd, `CP0_STATUS, 0, 0, 0, 0, 32'h0000_0010);
        addRow("status out after eret", opWait, selSt, 0, 0, 0, 0, 32'h0000_0010);
        addRow("usermode after eret", opWait, selUm, 1, 0, 0, 0, 1);
        addRow("int drive", opInt, 0, 32'h2A, 0, 0, 0, 0);
        addRow("int mirror", opWait, selIp, 1, 0, 0, 0, 32'hAB);  // Soft bits stay 2'b11
    endtask

    initial begin
        wordT rdVal;
        wordT count0;
        wordT offset;
        logic errVal;
        int   waitCnt;
        rst = 1'b1;
        psel_i = 1'b0;
        penable_i = 1'b0;
        pwrite_i = 1'b0;
        paddr_i = '0;
        pwdata_i = '0;
        exc_valid_i = 1'b0;
        exc_type_i = '0;
        pc_i = '0;
        bad_addr_i = '0;
        in_slot_i = 1'b0;
        cp_num_i = '0;
        int_i = '0;
        errors = 0;
        checks = 0;
        lcgState = 32'h9c27_316c;
        rowsReady = 1'b0;
        buildTable();
        rowsReady = 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        apbXfer(1'b0, `CP0_COUNT, '0, rdVal, errVal);
        checkValue("count near zero", 1, rdVal < 16);

        foreach (nameQ[i]) begin
            case (opQ[i])
                opWr, opRd: begin
                    apbXfer(opQ[i] == opWr, argQ[i], dataQ[i], rdVal, errVal);
                    checkValue({nameQ[i], " pslverr"}, !isMapped(argQ[i]), errVal);
                    if (opQ[i] == opRd)
                        checkValue(nameQ[i], expQ[i], rdVal);
                end
                opExc: begin
                    @(posedge clk);
                    exc_valid_i <= 1'b1;
                    exc_type_i  <= excTypeT'(argQ[i]);
                    pc_i        <= pcQ[i];
                    bad_addr_i  <= badQ[i];
                    in_slot_i   <= slotQ[i];
                    cp_num_i    <= dataQ[i][1:0];
                    @(posedge clk);
                    exc_valid_i <= 1'b0;
                end
                opInt: begin
                    @(posedge clk);
                    int_i <= dataQ[i][5:0];
                end
                default: begin
                    repeat (dataQ[i]) @(posedge clk);
                    @(negedge clk);
                    case (argQ[i])
                        selUm:   checkValue(nameQ[i], expQ[i], usermode_o);
                        selTmr:  checkValue(nameQ[i], expQ[i], timer_int_o);
                        selSt:   checkValue(nameQ[i], expQ[i], status_o);
                        selEpc:  checkValue(nameQ[i], expQ[i], epc_o);
                        selCs:   checkValue(nameQ[i], expQ[i], cause_o);
                        default: checkValue(nameQ[i], expQ[i], cause_o[15:8]);
                    endcase
                end
            endcase
        end

        // Timer, Compare set a few cycles ahead of Count
        apbXfer(1'b0, `CP0_COUNT, '0, count0, errVal);
        apbXfer(1'b0, `CP0_COUNT, '0, rdVal, errVal);
        checkValue("count increases", 1, rdVal > count0);
        offset = 8 + lcgNext() % 8;
        apbXfer(1'b1, `CP0_COMPARE, rdVal + offset, rdVal, errVal);
        waitCnt = 0;
        do begin
            @(negedge clk);
            waitCnt++;
        end while (!timer_int_o && waitCnt < offset + 4);
        checkValue("timer int rises", 1, timer_int_o);
        apbXfer(1'b1, `CP0_COMPARE, '0, rdVal, errVal);
        @(negedge clk);
        checkValue("timer int clears", 0, timer_int_o);

        errors += UUT.svaChk.failCount;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

    // Watchdog, 64 cycles per row plus the timer part
    initial begin
        wait (rowsReady);
        #((nameQ.size() + 16) * 64 * 20);
        $display("Timeout, the tests did not finish in time");
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Testbench failed");
        $finish;
    end

endmodule

//--- test/cp0_sva.sv
/*
 * CP0 assertions
 * APB response, reset and timer interrupt properties, bound into the top level
 */
`timescale 1ns/10ps
`include "cp0_settings.svh"

module cp0Sva (
    input logic                    clk,
    input logic                    rst,
    input logic                    psel_i,
    input logic                    penable_i,
    input logic                    pwrite_i,
    input logic [`CP0_PADDR_W-1:0] paddr_i,
    input logic                    pready_o,
    input logic                    pslverr_o,
    input logic                    timer_int_o,
    input logic                    usermode_o
);

    int   failCount = 0;
    logic cmpWrite;
    logic regMapped;

    assign cmpWrite  = pready_o & pwrite_i & (paddr_i[6:2] == `CP0_COMPARE);
    assign regMapped = paddr_i[6:2] inside {`CP0_BADVADDR, `CP0_COUNT, `CP0_COMPARE,
                                            `CP0_STATUS, `CP0_CAUSE, `CP0_EPC, `CP0_PRID};

    // Ready exactly in the cycle after a setup phase
    readyInAccess: assert property (@(posedge clk) disable iff (rst)
        pready_o == (psel_i && penable_i && $past(psel_i && !penable_i)))
    else begin
        failCount++;
        $error("pready outside the access phase");
    end

    // Error only with ready, and only for an unmapped number
    errWithReady: assert property (@(posedge clk) disable iff (rst)
        pslverr_o == (pready_o && !regMapped))
    else begin
        failCount++;
        $error("pslverr does not match the access and address");
    end

    timerAck: assert property (@(posedge clk) disable iff (rst)
        cmpWrite |=> !timer_int_o)
    else begin
        failCount++;
        $error("timer interrupt still set after a Compare write");
    end

    // Outputs quiet while in reset
    resetQuiet: assert property (@(posedge clk)
        rst && $past(rst) |-> !pready_o && !pslverr_o && !timer_int_o && !usermode_o)
    else begin
        failCount++;
        $error("output high during reset");
    end

endmodule

bind cp0Top cp0Sva svaChk (.*);

//--- hdl/cp0Top.sv
/*
 * CP0 top level
 * APB register port in front of the exception and timer units
 */
`timescale 1ns/10ps
`include "cp0_settings.svh"

module cp0Top import cp0Pkg::*; (
    input  logic                    clk,
    input  logic                    rst,

    // APB slave
    input  logic                    psel_i,
    input  logic                    penable_i,
    input  logic                    pwrite_i,
    input  logic [`CP0_PADDR_W-1:0] paddr_i,
    input  wordT                    pwdata_i,
    output wordT                    prdata_o,
    output logic                    pready_o,
    output logic                    pslverr_o,

    // Pipeline side
    input  logic                    exc_valid_i,
    input  excTypeT                 exc_type_i,
    input  wordT                    pc_i,
    input  wordT                    bad_addr_i,
    input  logic                    in_slot_i,
    input  cpNumT                   cp_num_i,
    input  hwIntT                   int_i,

    output wordT                    status_o,
    output wordT                    cause_o,
    output wordT                    epc_o,
    output logic                    usermode_o,
    output logic                    timer_int_o
);

    cp0RegBus excBus ();
    cp0RegBus timerBus ();

    apbRegPort apbPort (
        .clk       (clk),
        .rst       (rst),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .excBus    (excBus.master),
        .timerBus  (timerBus.master)
    );

    excUnit exc (
        .clk         (clk),
        .rst         (rst),
        .regBus      (excBus.target),
        .exc_valid_i (exc_valid_i),
        .exc_type_i  (exc_type_i),
        .pc_i        (pc_i),
        .bad_addr_i  (bad_addr_i),
        .in_slot_i   (in_slot_i),
        .cp_num_i    (cp_num_i),
        .int_i       (int_i),
        .status_o    (status_o),
        .cause_o     (cause_o),
        .epc_o       (epc_o),
        .usermode_o  (usermode_o)
    );

    timerUnit timer (
        .clk         (clk),
        .rst         (rst),
        .regBus      (timerBus.target),
        .timer_int_o (timer_int_o)
    );

endmodule

//--- hdl/timerUnit.sv
/*
 * CP0 timer unit
 * Count and Compare registers with the timer interrupt
 */
`timescale 1ns/10ps
`include "cp0_settings.svh"

module timerUnit import cp0Pkg::*; (
    input  logic     clk,
    input  logic     rst,
    cp0RegBus.target regBus,
    output logic     timer_int_o
);

    wordT count;
    wordT compare;
    logic countWrite;
    logic compareWrite;
    logic match;

    assign countWrite   = regBus.wrEn & (regBus.regNum == `CP0_COUNT);
    assign compareWrite = regBus.wrEn & (regBus.regNum == `CP0_COMPARE);
    assign match        = (compare != '0) && (count == compare);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count       <= '0;
            compare     <= '0;
            timer_int_o <= 1'b0;
        end else begin
            // A written value replaces this cycle's increment
            count <= countWrite ? regBus.wrData : count + 32'd1;

            if (compareWrite) begin
                compare     <= regBus.wrData;
                timer_int_o <= 1'b0;  // Acknowledge
            end else if (match) begin
                timer_int_o <= 1'b1;
            end
        end
    end

    always_comb begin
        regBus.hit    = 1'b1;
        regBus.rdData = '0;
        case (regBus.regNum)
            `CP0_COUNT:   regBus.rdData = count;
            `CP0_COMPARE: regBus.rdData = compare;
            default:      regBus.hit    = 1'b0;
        endcase
    end

endmodule

//--- hdl/excUnit.sv
/*
 * CP0 exception unit
 * Status, Cause, EPC, BadVAddr and PrId, exception entry and ERET
 */
`timescale 1ns/10ps
`include "cp0_settings.svh"

module excUnit import cp0Pkg::*; (
    input  logic     clk,
    input  logic     rst,
    cp0RegBus.target regBus,
    input  logic     exc_valid_i,
    input  excTypeT  exc_type_i,
    input  wordT     pc_i,
    input  wordT     bad_addr_i,
    input  logic     in_slot_i,
    input  cpNumT    cp_num_i,
    input  hwIntT    int_i,
    output wordT     status_o,
    output wordT     cause_o,
    output wordT     epc_o,
    output logic     usermode_o
);

    localparam int ExlBit = 1;
    localparam int ErlBit = 2;
    localparam int UmBit  = 4;
    localparam int IvBit  = 23;

    wordT       status;  // Unmasked bits stay zero
    wordT       epc;
    wordT       badVAddr;
    logic       causeBd;
    cpNumT      causeCe;
    logic       causeIv;
    logic [7:0] causeIp;
    excCodeT    causeExcCode;
    wordT       cause;

    logic       excEntry;
    excCodeT    entryCode;
    logic       regWrite;

    assign cause = {
        causeBd,      // 31
        1'b0,
        causeCe,      // 29:28
        4'b0,
        causeIv,      // 23
        7'b0,
        causeIp,      // 15:8
        1'b0,
        causeExcCode, // 6:2
        2'b0
    };

    // Type to ExcCode, ERET and unknown types do not enter
    always_comb begin
        excEntry  = 1'b1;
        entryCode = `EXCC_INTR;
        case (exc_type_i)
            `EXCT_INTR: entryCode = `EXCC_INTR;
            `EXCT_CPU:  entryCode = `EXCC_CPU;
            `EXCT_RI:   entryCode = `EXCC_RI;
            `EXCT_OV:   entryCode = `EXCC_OV;
            `EXCT_TRAP: entryCode = `EXCC_TR;
            `EXCT_SYSC: entryCode = `EXCC_SYSC;
            `EXCT_BP:   entryCode = `EXCC_BP;
            `EXCT_ADEL: entryCode = `EXCC_ADEL;
            `EXCT_ADES: entryCode = `EXCC_ADES;
            default:    excEntry  = 1'b0;
        endcase
    end

    assign regWrite = regBus.wrEn & regBus.hit;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            status       <= `STATUS_RST;
            epc          <= '0;
            badVAddr     <= '0;
            causeBd      <= 1'b0;
            causeCe      <= '0;
            causeIv      <= 1'b0;
            causeIp      <= '0;
            causeExcCode <= '0;
        end else begin
            causeIp[7:2] <= int_i;  // Sampled every cycle

            if (exc_valid_i) begin  // Wins over a register write
                if (excEntry) begin
                    // Nested exception keeps the first EPC
                    if (!status[ExlBit]) begin
                        epc     <= in_slot_i ? pc_i - 32'd4 : pc_i;
                        causeBd <= in_slot_i;
                    end
                    status[ExlBit] <= 1'b1;
                    causeExcCode   <= entryCode;
                    if (exc_type_i == `EXCT_ADEL || exc_type_i == `EXCT_ADES)
                        badVAddr <= bad_addr_i;
                    if (exc_type_i == `EXCT_CPU)
                        causeCe <= cp_num_i;
                end else if (exc_type_i == `EXCT_ERET) begin
                    status[ExlBit] <= 1'b0;
                end
            end else if (regWrite) begin
                case (regBus.regNum)
                    `CP0_STATUS:   status <= regBus.wrData & `STATUS_WMASK;
                    `CP0_CAUSE: begin
                        causeIv      <= regBus.wrData[IvBit];
                        causeIp[1:0] <= regBus.wrData[9:8];  // Software bits
                    end
                    `CP0_EPC:      epc <= regBus.wrData;
                    `CP0_BADVADDR: badVAddr <= regBus.wrData;
                    default: ;     // PrId is read only
                endcase
            end
        end
    end

    // Read side
    always_comb begin
        regBus.hit    = 1'b1;
        regBus.rdData = '0;
        case (regBus.regNum)
            `CP0_STATUS:   regBus.rdData = status;
            `CP0_CAUSE:    regBus.rdData = cause;
            `CP0_EPC:      regBus.rdData = epc;
            `CP0_BADVADDR: regBus.rdData = badVAddr;
            `CP0_PRID:     regBus.rdData = `PRID_VALUE;
            default:       regBus.hit    = 1'b0;
        endcase
    end

    assign status_o   = status;
    assign cause_o    = cause;
    assign epc_o      = epc;
    assign usermode_o = status[UmBit] & ~(status[ErlBit] | status[ExlBit]);

endmodule

//--- hdl/apbRegPort.sv
/*
 * APB register port
 * Zero-wait-state APB slave, turns transfers into register bus accesses
 * and merges read data and hit flags of the register units
 */
`timescale 1ns/10ps
`include "cp0_settings.svh"

module apbRegPort import cp0Pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    psel_i,
    input  logic                    penable_i,
    input  logic                    pwrite_i,
    input  logic [`CP0_PADDR_W-1:0] paddr_i,
    input  wordT                    pwdata_i,
    output wordT                    prdata_o,
    output logic                    pready_o,
    output logic                    pslverr_o,
    cp0RegBus.master                excBus,
    cp0RegBus.master                timerBus
);

    logic   setupSeen;
    logic   access;
    regNumT regNum;

    // Setup phase seen last cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            setupSeen <= 1'b0;
        end else begin
            setupSeen <= psel_i & ~penable_i;
        end
    end

    assign access = setupSeen & psel_i & penable_i;
    assign regNum = paddr_i[6:2];  // Word addressed

    assign excBus.regNum   = regNum;
    assign excBus.wrEn     = access & pwrite_i;
    assign excBus.wrData   = pwdata_i;
    assign timerBus.regNum = regNum;
    assign timerBus.wrEn   = access & pwrite_i;
    assign timerBus.wrData = pwdata_i;

    // Units return zero on a miss, so OR is enough
    assign prdata_o  = access ? (excBus.rdData | timerBus.rdData) : '0;
    assign pready_o  = access;
    assign pslverr_o = access & ~(excBus.hit | timerBus.hit);

endmodule

//--- hdl/cp0RegBus.sv
/*
 * CP0 register bus
 * One register access channel from the APB port to a register unit
 */
`timescale 1ns/10ps

interface cp0RegBus import cp0Pkg::*; ();

    regNumT regNum;
    logic   wrEn;    // Access cycle of a write
    wordT   wrData;
    wordT   rdData;  // Zero when not our register
    logic   hit;

    modport master (
        output regNum, wrEn, wrData,
        input  rdData, hit
    );

    modport target (
        input  regNum, wrEn, wrData,
        output rdData, hit
    );

endinterface

//--- hdl/cp0Pkg.sv
/*
 * CP0 package
 * Vector types shared by the register units, the APB port and the testbench
 */
`include "cp0_settings.svh"

package cp0Pkg;

    // Data word, also used for addresses
    typedef logic [`CP0_WORD_W-1:0] wordT;

    // CP0 register number
    typedef logic [`CP0_REGNUM_W-1:0] regNumT;

    // Exception type as signalled by the pipeline
    typedef logic [`CP0_EXCTYPE_W-1:0] excTypeT;

    // Cause.ExcCode field
    typedef logic [4:0] excCodeT;

    // Hardware interrupt lines, map onto Cause.IP[7:2]
    typedef logic [`CP0_HWINT_W-1:0] hwIntT;

    // Coprocessor number for CpU
    typedef logic [1:0] cpNumT;

endpackage

//--- hdl/cp0_settings.svh
/*
 * CP0 settings
 * Widths, register numbers, exception type and code values, reset constants
 */
`ifndef CP0_SETTINGS_SVH
`define CP0_SETTINGS_SVH

`define CP0_WORD_W      32
`define CP0_REGNUM_W    5
`define CP0_EXCTYPE_W   4
`define CP0_HWINT_W     6
`define CP0_PADDR_W     7   // Register number in paddr[6:2]

// Register numbers
`define CP0_BADVADDR    5'd8
`define CP0_COUNT       5'd9
`define CP0_COMPARE     5'd11
`define CP0_STATUS      5'd12
`define CP0_CAUSE       5'd13
`define CP0_EPC         5'd14
`define CP0_PRID        5'd15

// Exception types from the pipeline
`define EXCT_INTR       4'd1
`define EXCT_CPU        4'd2
`define EXCT_RI         4'd3
`define EXCT_OV         4'd4
`define EXCT_TRAP       4'd5
`define EXCT_SYSC       4'd6
`define EXCT_BP         4'd7
`define EXCT_ADEL       4'd8
`define EXCT_ADES       4'd9
`define EXCT_ERET       4'd10

// Cause ExcCode values
`define EXCC_INTR       5'd0
`define EXCC_ADEL       5'd4
`define EXCC_ADES       5'd5
`define EXCC_SYSC       5'd8
`define EXCC_BP         5'd9
`define EXCC_RI         5'd10
`define EXCC_CPU        5'd11
`define EXCC_OV         5'd12
`define EXCC_TR         5'd13

`define STATUS_RST      32'h0040_0004   // BEV and ERL set
`define PRID_VALUE      32'h0001_8000
`define STATUS_WMASK    32'h1040_FF17   // CU0, BEV, IM, UM, ERL, EXL, IE

`endif
